// File: rtl/mips_pkg.sv
package mips_pkg;

    localparam int DATA_W    = 32;  // data word
    localparam int DWORD_W   = 64;  // hi and lo side by side
    localparam int ADDR_W    = 8;   // apb byte address
    localparam int DIV_STEPS = 32;  // quotient bits, one per cycle

    // apb register map, one word per register
    typedef enum logic [ADDR_W-1:0] {
        REG_OP1     = 8'h00,  // dividend
        REG_OP2     = 8'h04,  // divisor
        REG_CTRL    = 8'h08,  // wr: bit0 start, bit1 signed / rd: bit0 busy
        REG_LO      = 8'h0C,  // quotient, read only
        REG_HI      = 8'h10,  // remainder, read only
        REG_COUNT   = 8'h14,
        REG_COMPARE = 8'h18
    } apb_reg_e;

    typedef enum logic [1:0] {
        DIV_FREE    = 2'b00,
        DIV_BY_ZERO = 2'b01,
        DIV_ON      = 2'b10,
        DIV_END     = 2'b11
    } div_state_e;

endpackage

// File: rtl/div_if.sv
`timescale 1ns/100ps

interface div_if;

    logic                          start;       // one cycle pulse
    logic                          signed_div;
    logic [mips_pkg::DATA_W-1:0]   op1;         // dividend
    logic [mips_pkg::DATA_W-1:0]   op2;         // divisor
    logic [mips_pkg::DWORD_W-1:0]  result;      // {hi, lo}
    logic                          ready;       // result valid this cycle
    logic                          busy;

    modport host (
        output start,
        output signed_div,
        output op1,
        output op2,
        input  result,
        input  ready,
        input  busy
    );

    modport ctrl (
        input  start,
        input  op2,
        output ready,
        output busy
    );

    modport data (
        input  op1,
        input  op2,
        input  signed_div,
        output result
    );

endinterface

// File: rtl/div_fsm.sv
`timescale 1ns/100ps

module div_fsm (
    input  logic  clk,
    input  logic  rst_n_i,
    div_if.ctrl   div_bus,
    output logic  load_o,
    output logic  step_o,
    output logic  zero_o
);

    mips_pkg::div_state_e state_q;
    mips_pkg::div_state_e state_d;
    logic [5:0]           step_cnt_q;  // 0 is the load cycle, then one per bit
    logic                 last_step;

    assign last_step = (step_cnt_q == 6'(mips_pkg::DIV_STEPS));

    always_comb begin
        state_d = state_q;
        case (state_q)
            mips_pkg::DIV_FREE: begin
                if (div_bus.start) begin
                    if (div_bus.op2 == '0) begin
                        state_d = mips_pkg::DIV_BY_ZERO;
                    end else begin
                        state_d = mips_pkg::DIV_ON;
                    end
                end
            end
            mips_pkg::DIV_BY_ZERO: begin
                state_d = mips_pkg::DIV_END;  // skip the iterations
            end
            mips_pkg::DIV_ON: begin
                if (last_step) begin
                    state_d = mips_pkg::DIV_END;
                end
            end
            mips_pkg::DIV_END: begin
                state_d = mips_pkg::DIV_FREE;
            end
            default: begin
                state_d = mips_pkg::DIV_FREE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= mips_pkg::DIV_FREE;
            step_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == mips_pkg::DIV_ON) begin
                step_cnt_q <= step_cnt_q + 6'd1;
            end else begin
                step_cnt_q <= '0;
            end
        end
    end

    assign load_o = (state_q == mips_pkg::DIV_ON) && (step_cnt_q == '0);
    assign step_o = (state_q == mips_pkg::DIV_ON) && (step_cnt_q != '0);
    assign zero_o = (state_q == mips_pkg::DIV_BY_ZERO);

    assign div_bus.ready = (state_q == mips_pkg::DIV_END);
    assign div_bus.busy  = (state_q != mips_pkg::DIV_FREE);

endmodule

// File: rtl/div_datapath.sv
`timescale 1ns/100ps

module div_datapath (
    input  logic  clk,
    input  logic  rst_n_i,
    div_if.data   div_bus,
    input  logic  load_i,
    input  logic  step_i,
    input  logic  zero_i
);

    // {remainder, quotient}
    logic [mips_pkg::DATA_W+mips_pkg::DIV_STEPS-1:0] acc_q;
    logic [mips_pkg::DATA_W+mips_pkg::DIV_STEPS:0]   shifted;  // spare top bit
    logic [mips_pkg::DATA_W:0]                       diff;
    logic [mips_pkg::DATA_W-1:0]                     dividend_abs;
    logic [mips_pkg::DATA_W-1:0]                     divisor_abs;
    logic [mips_pkg::DATA_W-1:0]                     quot;
    logic [mips_pkg::DATA_W-1:0]                     rem;
    logic                                            op1_neg;
    logic                                            op2_neg;
    logic                                            neg_quot;
    logic                                            neg_rem;

    assign op1_neg = div_bus.signed_div & div_bus.op1[mips_pkg::DATA_W-1];
    assign op2_neg = div_bus.signed_div & div_bus.op2[mips_pkg::DATA_W-1];

    assign dividend_abs = op1_neg ? -div_bus.op1 : div_bus.op1;
    assign divisor_abs  = op2_neg ? -div_bus.op2 : div_bus.op2;  // op2 held while busy

    assign shifted = {acc_q, 1'b0};
    assign diff    = shifted[mips_pkg::DATA_W+mips_pkg::DIV_STEPS:mips_pkg::DIV_STEPS]
                   - {1'b0, divisor_abs};  // trial subtract

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_q <= '0;
        end else if (zero_i) begin
            acc_q <= '0;
        end else if (load_i) begin
            acc_q <= {{mips_pkg::DATA_W{1'b0}}, dividend_abs};
        end else if (step_i) begin
            if (!diff[mips_pkg::DATA_W]) begin
                acc_q <= {diff[mips_pkg::DATA_W-1:0], shifted[mips_pkg::DIV_STEPS-1:1], 1'b1};
            end else begin
                // divisor did not fit, quotient bit 0
                acc_q <= shifted[mips_pkg::DATA_W+mips_pkg::DIV_STEPS-1:0];
            end
        end
    end

    assign quot = acc_q[mips_pkg::DIV_STEPS-1:0];
    assign rem  = acc_q[mips_pkg::DATA_W+mips_pkg::DIV_STEPS-1:mips_pkg::DIV_STEPS];

    // truncate toward zero, remainder follows the dividend
    assign neg_quot = op1_neg ^ op2_neg;
    assign neg_rem  = op1_neg;

    assign div_bus.result = {neg_rem ? -rem : rem, neg_quot ? -quot : quot};

endmodule

// File: rtl/cp0_timer.sv
`timescale 1ns/100ps

module cp0_timer (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         count_we_i,
    input  logic                         compare_we_i,
    input  logic [mips_pkg::DATA_W-1:0]  wdata_i,
    output logic [mips_pkg::DATA_W-1:0]  count_o,
    output logic [mips_pkg::DATA_W-1:0]  compare_o,
    output logic                         timer_int_o
);

    logic [mips_pkg::DATA_W-1:0] count_q;
    logic [mips_pkg::DATA_W-1:0] compare_q;
    logic                        int_q;
    logic                        match;

    assign match = (compare_q != '0) && (count_q == compare_q);  // compare 0 disables

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (count_we_i) begin
            count_q <= wdata_i;
        end else begin
            count_q <= count_q + 1'b1;  // free running
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            compare_q <= '0;
            int_q     <= 1'b0;
        end else begin
            if (compare_we_i) begin
                compare_q <= wdata_i;
                int_q     <= 1'b0;  // writing compare acknowledges
            end else if (match) begin
                int_q <= 1'b1;  // sticky
            end
        end
    end

    assign count_o     = count_q;
    assign compare_o   = compare_q;
    assign timer_int_o = int_q;

endmodule

// File: rtl/hilo_apb_regs.sv
`timescale 1ns/100ps

module hilo_apb_regs (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  logic [mips_pkg::ADDR_W-1:0]  paddr_i,
    input  logic [mips_pkg::DATA_W-1:0]  pwdata_i,
    output logic [mips_pkg::DATA_W-1:0]  prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    div_if.host                          div_bus,
    input  logic [mips_pkg::DATA_W-1:0]  count_i,
    input  logic [mips_pkg::DATA_W-1:0]  compare_i,
    output logic                         count_we_o,
    output logic                         compare_we_o,
    output logic [mips_pkg::DATA_W-1:0]  timer_wdata_o
);

    logic [mips_pkg::DATA_W-1:0] op1_q;
    logic [mips_pkg::DATA_W-1:0] op2_q;
    logic [mips_pkg::DATA_W-1:0] hi_q;
    logic [mips_pkg::DATA_W-1:0] lo_q;
    logic                        signed_q;
    logic                        access;
    logic                        wr_en;
    logic                        hilo_sel;
    logic                        addr_ok;
    logic                        op_wr_ok;

    assign access   = psel_i & penable_i;
    assign hilo_sel = (paddr_i == mips_pkg::REG_LO) || (paddr_i == mips_pkg::REG_HI);

    // result reads wait for the divider, everything else is zero wait
    assign pready_o = access & ~(~pwrite_i & hilo_sel & div_bus.busy);
    assign wr_en    = access & pwrite_i;  // writes never stall
    assign op_wr_ok = wr_en & ~div_bus.busy;

    always_comb begin
        addr_ok  = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            mips_pkg::REG_OP1:     prdata_o = op1_q;
            mips_pkg::REG_OP2:     prdata_o = op2_q;
            mips_pkg::REG_CTRL:    prdata_o = {{(mips_pkg::DATA_W-1){1'b0}}, div_bus.busy};
            mips_pkg::REG_LO:      prdata_o = lo_q;
            mips_pkg::REG_HI:      prdata_o = hi_q;
            mips_pkg::REG_COUNT:   prdata_o = count_i;
            mips_pkg::REG_COMPARE: prdata_o = compare_i;
            default:               addr_ok  = 1'b0;  // hole in the map
        endcase
    end

    assign pslverr_o = pready_o & (~addr_ok | (pwrite_i & hilo_sel));

    assign div_bus.start = op_wr_ok & (paddr_i == mips_pkg::REG_CTRL) & pwdata_i[0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            op1_q    <= '0;
            op2_q    <= '0;
            signed_q <= 1'b0;
        end else begin
            if (op_wr_ok && paddr_i == mips_pkg::REG_OP1) begin
                op1_q <= pwdata_i;
            end
            if (op_wr_ok && paddr_i == mips_pkg::REG_OP2) begin
                op2_q <= pwdata_i;
            end
            if (div_bus.start) begin
                signed_q <= pwdata_i[1];  // held for the whole divide
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (div_bus.ready) begin
            hi_q <= div_bus.result[mips_pkg::DWORD_W-1:mips_pkg::DATA_W];  // remainder
            lo_q <= div_bus.result[mips_pkg::DATA_W-1:0];                  // quotient
        end
    end

    assign div_bus.op1        = op1_q;
    assign div_bus.op2        = op2_q;
    assign div_bus.signed_div = signed_q;

    assign count_we_o    = wr_en & (paddr_i == mips_pkg::REG_COUNT);
    assign compare_we_o  = wr_en & (paddr_i == mips_pkg::REG_COMPARE);
    assign timer_wdata_o = pwdata_i;

endmodule

// File: rtl/muldiv_cp0_top.sv
`timescale 1ns/100ps

module muldiv_cp0_top (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  logic [mips_pkg::ADDR_W-1:0]  paddr_i,
    input  logic [mips_pkg::DATA_W-1:0]  pwdata_i,
    output logic [mips_pkg::DATA_W-1:0]  prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    output logic                         timer_int_o
);

    logic [mips_pkg::DATA_W-1:0] count;
    logic [mips_pkg::DATA_W-1:0] compare;
    logic [mips_pkg::DATA_W-1:0] timer_wdata;
    logic                        count_we;
    logic                        compare_we;
    logic                        div_load;
    logic                        div_step;
    logic                        div_zero;

    div_if div_bus ();  // register block <-> divider

    hilo_apb_regs hilo_apb_regs_0 (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .div_bus       (div_bus.host),
        .count_i       (count),
        .compare_i     (compare),
        .count_we_o    (count_we),
        .compare_we_o  (compare_we),
        .timer_wdata_o (timer_wdata)
    );

    div_fsm div_fsm_0 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .div_bus (div_bus.ctrl),
        .load_o  (div_load),
        .step_o  (div_step),
        .zero_o  (div_zero)
    );

    div_datapath div_datapath_0 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .div_bus (div_bus.data),
        .load_i  (div_load),
        .step_i  (div_step),
        .zero_i  (div_zero)
    );

    cp0_timer cp0_timer_0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .count_we_i   (count_we),
        .compare_we_i (compare_we),
        .wdata_i      (timer_wdata),
        .count_o      (count),
        .compare_o    (compare),
        .timer_int_o  (timer_int_o)
    );

endmodule

// File: sim/tb_tasks.svh
task automatic apb_transfer(
    input  logic                        write,
    input  logic [mips_pkg::ADDR_W-1:0] addr,
    input  logic [mips_pkg::DATA_W-1:0] wdata,
    output logic [mips_pkg::DATA_W-1:0] rdata,
    output logic                        err
);
    @(posedge clk);
    psel_i    <= 1'b1;  // setup phase
    penable_i <= 1'b0;
    pwrite_i  <= write;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk);
    penable_i <= 1'b1;
    @(negedge clk);
    while (pready_o !== 1'b1) begin
        @(negedge clk);  // wait states
    end
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk);
    psel_i    <= 1'b0;  // back to idle
    penable_i <= 1'b0;
endtask

task automatic apb_write(
    input  logic [mips_pkg::ADDR_W-1:0] addr,
    input  logic [mips_pkg::DATA_W-1:0] data,
    output logic                        err
);
    logic [mips_pkg::DATA_W-1:0] unused;
    apb_transfer(1'b1, addr, data, unused, err);
endtask

task automatic apb_read(
    input  logic [mips_pkg::ADDR_W-1:0] addr,
    output logic [mips_pkg::DATA_W-1:0] rdata,
    output logic                        err
);
    apb_transfer(1'b0, addr, '0, rdata, err);
endtask

task automatic check_value(
    input logic [31:0] actual,
    input logic [31:0] expected,
    input string       what
);
    if (actual !== expected) begin
        $display("ERROR at %0t: %s, got %h, expected %h", $time, what, actual, expected);
        $display("Testbench failed");
        $fatal(1);
    end
endtask

// quotient truncates toward zero, remainder keeps the dividend's sign
function automatic logic [63:0] ref_div(
    input logic        sgn,
    input logic [31:0] a,
    input logic [31:0] b
);
    longint na;
    longint nb;
    longint q;
    longint r;
    if (b == 32'd0) begin
        return 64'd0;  // zero divisor gives zero
    end
    if (sgn) begin
        na = longint'($signed(a));
        nb = longint'($signed(b));
    end else begin
        na = longint'(a);
        nb = longint'(b);
    end
    q = na / nb;
    r = na % nb;
    return {r[31:0], q[31:0]};  // {hi, lo}
endfunction

// File: sim/tb_top.sv
`timescale 1ns/100ps

module tb_top;

    localparam int NUM_CASES  = 25;  // lines in div_cases.txt
    localparam int CASE_WORDS = 5;   // signed, op1, op2, lo, hi
    localparam int NUM_RANDOM = 20;
    // about 50 cycles per divide with its bus traffic, the timer part about 700
    localparam int TIMEOUT_CYCLES = (NUM_CASES + NUM_RANDOM) * 60 + 1200;

    logic                        clk;
    logic                        rst_n_i;
    logic                        psel_i;
    logic                        penable_i;
    logic                        pwrite_i;
    logic [mips_pkg::ADDR_W-1:0] paddr_i;
    logic [mips_pkg::DATA_W-1:0] pwdata_i;
    logic [mips_pkg::DATA_W-1:0] prdata_o;
    logic                        pready_o;
    logic                        pslverr_o;
    logic                        timer_int_o;

    logic [31:0] case_mem [0:NUM_CASES*CASE_WORDS-1];
    int          cycle_cnt = 0;

    `include "tb_tasks.svh"

    muldiv_cp0_top u_dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .timer_int_o (timer_int_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout: simulation ran too long");
            $display("Testbench failed");
            $fatal(1);
        end
    end

    task automatic run_divide(
        input logic        sgn,
        input logic [31:0] a,
        input logic [31:0] b,
        input logic [63:0] expected,
        input string       tag
    );
        logic [31:0] rd;
        logic        err;
        apb_write(mips_pkg::REG_OP1, a, err);
        apb_write(mips_pkg::REG_OP2, b, err);
        apb_write(mips_pkg::REG_CTRL, {30'd0, sgn, 1'b1}, err);
        apb_read(mips_pkg::REG_LO, rd, err);  // stalls until the divider is done
        check_value(rd, expected[31:0], $sformatf("%s LO", tag));
        check_value(32'(err), 32'd0, $sformatf("%s LO slave error", tag));
        apb_read(mips_pkg::REG_HI, rd, err);
        check_value(rd, expected[63:32], $sformatf("%s HI", tag));
    endtask

    initial begin
        int          i;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rd;
        logic [31:0] lo_keep;
        logic [63:0] exp_word;
        logic        err;

        rst_n_i   <= 1'b0;
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
        paddr_i   <= '0;
        pwdata_i  <= '0;
        a = $urandom(32'hd4f978e2);
        $readmemh("sim/div_cases.txt", case_mem);
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;

        for (i = 0; i < NUM_CASES; i++) begin
            run_divide(case_mem[i*CASE_WORDS][0], case_mem[i*CASE_WORDS+1],
                       case_mem[i*CASE_WORDS+2],
                       {case_mem[i*CASE_WORDS+4], case_mem[i*CASE_WORDS+3]},
                       $sformatf("file case %0d", i));
        end

        for (i = 0; i < NUM_RANDOM; i++) begin
            a = $urandom;
            b = $urandom >> ($urandom % 32);  // spread divisor sizes
            run_divide(1'b1, a, b, ref_div(1'b1, a, b), $sformatf("random case %0d", i));
        end

        // LO read straight after start has to wait for the result
        apb_write(mips_pkg::REG_OP1, 32'd1000, err);
        apb_write(mips_pkg::REG_OP2, 32'd7, err);
        apb_write(mips_pkg::REG_CTRL, 32'h1, err);
        apb_read(mips_pkg::REG_LO, rd, err);
        check_value(rd, 32'd142, "LO read during divide");
        apb_read(mips_pkg::REG_CTRL, rd, err);
        check_value(rd, 32'd0, "busy after stalled LO read");

        a = 32'hfffffc18;
        exp_word = ref_div(1'b1, a, 32'd7);
        apb_write(mips_pkg::REG_OP1, a, err);
        apb_write(mips_pkg::REG_OP2, 32'd7, err);
        apb_write(mips_pkg::REG_CTRL, 32'h3, err);
        apb_read(mips_pkg::REG_CTRL, rd, err);
        check_value(rd, 32'd1, "busy right after start");
        apb_write(mips_pkg::REG_OP1, 32'd5, err);  // ignored while busy
        apb_write(mips_pkg::REG_OP2, 32'd3, err);
        apb_read(mips_pkg::REG_LO, rd, err);
        check_value(rd, exp_word[31:0], "LO after operand writes while busy");
        apb_read(mips_pkg::REG_HI, rd, err);
        check_value(rd, exp_word[63:32], "HI after operand writes while busy");
        apb_read(mips_pkg::REG_OP1, rd, err);
        check_value(rd, a, "OP1 kept while busy");

        lo_keep = exp_word[31:0];
        apb_read(8'h1C, rd, err);
        check_value(32'(err), 32'd1, "slave error on read of 0x1C");
        apb_write(8'h1C, 32'h1, err);
        check_value(32'(err), 32'd1, "slave error on write of 0x1C");
        apb_write(mips_pkg::REG_LO, 32'h0bad0bad, err);
        check_value(32'(err), 32'd1, "slave error on write of LO");
        apb_read(mips_pkg::REG_LO, rd, err);
        check_value(rd, lo_keep, "LO after rejected write");

        apb_write(mips_pkg::REG_COMPARE, 32'd200, err);
        apb_write(mips_pkg::REG_COUNT, 32'd0, err);
        @(negedge clk);
        check_value(32'(timer_int_o), 32'd0, "timer interrupt right after count write");
        for (i = 0; i < 250 && timer_int_o !== 1'b1; i++) begin
            @(negedge clk);
        end
        check_value(32'(timer_int_o), 32'd1, "timer interrupt after count reached compare");
        apb_read(mips_pkg::REG_COUNT, rd, err);
        check_value(32'(rd >= 32'd200), 32'd1, "count past compare");
        apb_write(mips_pkg::REG_COMPARE, 32'h80000000, err);
        @(negedge clk);
        check_value(32'(timer_int_o), 32'd0, "timer interrupt after compare write");
        apb_write(mips_pkg::REG_COMPARE, 32'd0, err);  // compare 0 never matches
        apb_write(mips_pkg::REG_COUNT, 32'hffffff80, err);  // count wraps through 0 in the window
        repeat (300) begin
            @(negedge clk);
            check_value(32'(timer_int_o), 32'd0, "timer interrupt with compare 0");
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: sim/div_cases.txt
// columns: signed op1 op2 lo hi, all hex
// lo is the quotient, hi the remainder
// unsigned
0 0000000a 00000003 00000003 00000001
0 00000005 00000009 00000000 00000005
0 12345678 00000001 12345678 00000000
0 ffffffff ffffffff 00000001 00000000
0 ffffffff 00000001 ffffffff 00000000
0 ffffffff 00000010 0fffffff 0000000f
0 80000000 00000003 2aaaaaaa 00000002
0 00000000 00000007 00000000 00000000
0 00000064 00000007 0000000e 00000002
0 deadbeef 00010000 0000dead 0000beef
0 00000001 ffffffff 00000000 00000001
0 12345678 00000000 00000000 00000000
// signed
1 fffffff9 00000002 fffffffd ffffffff
1 00000007 fffffffe fffffffd 00000001
1 fffffff9 fffffffe 00000003 ffffffff
1 00000007 00000002 00000003 00000001
1 80000000 ffffffff 80000000 00000000
1 80000000 00000002 c0000000 00000000
1 80000000 00000007 edb6db6e fffffffe
1 7fffffff 80000000 00000000 7fffffff
1 ffffffff 00000001 ffffffff 00000000
1 00000064 fffffff9 fffffff2 00000002
1 ffffff9c 00000007 fffffff2 fffffffe
// signed, zero divisor
1 fffffff9 00000000 00000000 00000000
1 80000000 00000000 00000000 00000000

// File: build.f
+incdir+sim
rtl/mips_pkg.sv
rtl/div_if.sv
rtl/div_fsm.sv
rtl/div_datapath.sv
rtl/cp0_timer.sv
rtl/hilo_apb_regs.sv
rtl/muldiv_cp0_top.sv
sim/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --timescale 1ns/100ps --top-module tb_top \
    -f build.f -o tb_top_sim || { echo "compile failed"; exit 1; }

out=$(./obj_dir/tb_top_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Testbench passed" \
    && echo "simulation ok" \
    || { echo "simulation reported failure"; exit 1; }
